// File: filelist.f
+incdir+verilog
verilog/peak_monitor_pkg.sv
verilog/adc_spi_sampler.sv
verilog/window_timer.sv
verilog/peak_cache.sv
verilog/peak_regs.sv
verilog/peak_monitor_top.sv
test/adc_model.sv
test/peak_monitor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    -f filelist.f \
    --top-module peak_monitor_tb \
    -o peak_monitor_sim &&
./obj_dir/peak_monitor_sim | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }

// File: test/adc_model.sv
`include "peak_monitor_cfg.svh"

module adc_model
    import peak_monitor_pkg::*;
(
    input  logic               sclk,
    input  logic               cs_n,
    output logic [`NUM_CH-1:0] miso
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_FRAMES = 64;
    localparam int FB         = `FRAME_BITS;

    // conversion results per channel and frame, loaded by the testbench
    adc_sample_t          frame_vals [`NUM_CH][MAX_FRAMES];
    logic [FB-1:0]        word       [`NUM_CH];
    int                   frame_idx;
    int                   bit_idx;

    initial begin
        miso      = '0;
        frame_idx = 0;
        bit_idx   = 0;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // a new conversion word is latched when chip select falls
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge cs_n) begin
        for (int ch = 0; ch < `NUM_CH; ch++) begin
            // zero extension gives the two leading zeros
            word[ch] = FB'(frame_vals[ch][frame_idx % MAX_FRAMES]);
            miso[ch] <= word[ch][FB-1];
        end
        bit_idx   = 0;
        frame_idx = frame_idx + 1;
    end

    // the next bit goes out on each falling SCLK edge, MSB first
    always @(negedge sclk) begin
        if (!cs_n) begin
            bit_idx = bit_idx + 1;
            if (bit_idx < FB) begin
                for (int ch = 0; ch < `NUM_CH; ch++) begin
                    miso[ch] <= word[ch][FB-1-bit_idx];
                end
            end
        end
    end

endmodule

// File: test/peak_monitor_tb.sv
`include "peak_monitor_cfg.svh"

module peak_monitor_tb
    import peak_monitor_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 4;
    localparam int MAX_FRAMES   = 64;
    localparam int LOW_CYCLES   = `FRAME_BITS * 2 * `SCLK_HALF;
    localparam int FRAME_CYCLES = LOW_CYCLES + `CS_GAP;
    localparam int WATCHDOG_NS  = 12 * `WINDOW_DEFAULT * FRAME_CYCLES * CLK_PERIOD + 2000;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               sclk;
    logic               cs_n;
    logic [`NUM_CH-1:0] miso;
    logic               reg_wr;
    reg_addr_t          reg_addr;
    reg_data_t          reg_wdata;
    reg_data_t          reg_rdata;
    logic               window_done;

    int          seed = 89174;
    int          mismatches = 0;
    int          failures = 0;
    logic        idle_expected = 1'b0;
    adc_sample_t exp_vals [`NUM_CH][MAX_FRAMES];
    adc_sample_t exp_held [`NUM_CH];
    adc_sample_t run_max  [`NUM_CH];
    int          tb_win_len = `WINDOW_DEFAULT;
    int          frames_in_win = 0;
    int          done_frames = 0;
    int          exp_windows = 0;
    logic        cs_prev = 1'b1;
    logic        sclk_prev = 1'b0;
    logic        seen_rise = 1'b0;
    int          low_cnt = 0;
    int          high_cnt = 0;
    int          rise_cnt = 0;
    int          cycle = 0;
    int          last_done = 0;
    logic        done_seen = 1'b0;

    peak_monitor_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .sclk        (sclk),
        .cs_n        (cs_n),
        .miso        (miso),
        .reg_wr      (reg_wr),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .window_done (window_done)
    );

    adc_model u_adc (
        .sclk (sclk),
        .cs_n (cs_n),
        .miso (miso)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pin level checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_sclk_needs_cs: assert property (@(posedge clk) disable iff (!rst_n)
        cs_n |-> !sclk) else begin
        failures++;
        $display("sclk toggled while cs_n was high");
    end

    a_idle_pins: assert property (@(posedge clk) disable iff (!rst_n)
        idle_expected |-> (cs_n && !sclk)) else begin
        failures++;
        $display("SPI pins were active while the sampler should be idle");
    end

    a_idle_no_done: assert property (@(posedge clk) disable iff (!rst_n)
        idle_expected |-> !window_done) else begin
        failures++;
        $display("window_done pulsed while the sampler was idle");
    end

    // frame shape, expected peaks and window spacing, sampled mid cycle
    always @(negedge clk) begin
        if (rst_n) begin
            cycle++;
            if (cs_n && !cs_prev) begin
                assert (low_cnt == LOW_CYCLES) else begin
                    mismatches++;
                    $display("MISMATCH cs_n low cycles: got %h expected %h", low_cnt, LOW_CYCLES);
                end
                assert (rise_cnt == `FRAME_BITS) else begin
                    mismatches++;
                    $display("MISMATCH sclk rises: got %h expected %h", rise_cnt, `FRAME_BITS);
                end
                high_cnt  = 1;
                seen_rise = 1'b1;
                for (int ch = 0; ch < `NUM_CH; ch++) begin
                    if (exp_vals[ch][done_frames] > run_max[ch]) begin
                        run_max[ch] = exp_vals[ch][done_frames];
                    end
                end
                done_frames++;
                frames_in_win++;
                if (frames_in_win >= tb_win_len) begin
                    for (int ch = 0; ch < `NUM_CH; ch++) begin
                        exp_held[ch] = run_max[ch];
                        run_max[ch]  = '0;
                    end
                    frames_in_win = 0;
                    exp_windows++;
                end
            end else if (!cs_n && cs_prev) begin
                if (seen_rise) begin
                    assert (high_cnt == `CS_GAP) else begin
                        mismatches++;
                        $display("MISMATCH cs_n gap cycles: got %h expected %h",
                                 high_cnt, `CS_GAP);
                    end
                end
                low_cnt  = 1;
                rise_cnt = 0;
            end else if (cs_n) begin
                high_cnt++;
            end else begin
                low_cnt++;
                if (sclk && !sclk_prev) begin
                    rise_cnt++;
                end
            end
            if (window_done) begin
                if (done_seen) begin
                    assert (cycle - last_done == tb_win_len * FRAME_CYCLES) else begin
                        mismatches++;
                        $display("MISMATCH window_done spacing: got %h expected %h",
                                 cycle - last_done, tb_win_len * FRAME_CYCLES);
                    end
                end
                last_done = cycle;
                done_seen = 1'b1;
            end
            cs_prev   = cs_n;
            sclk_prev = sclk;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register port access
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr    <= 1'b0;
    endtask

    task automatic read_check(input reg_addr_t addr, input reg_data_t expected,
                              input string what);
        @(posedge clk);
        reg_addr <= addr;
        @(negedge clk);
        assert (reg_rdata === expected) else begin
            mismatches++;
            $display("MISMATCH reg_rdata %s: got %h expected %h", what, reg_rdata, expected);
        end
    endtask

    task automatic wait_window_done();
        int n;
        n = 0;
        @(negedge clk);
        while (!window_done && n < 20 * FRAME_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!window_done) begin
            failures++;
            $display("window_done never arrived");
        end
    endtask

    task automatic check_window(input logic odd_codes);
        for (int code = 1; code <= `NUM_CH; code++) begin
            write_reg(3'd2, reg_data_t'(code));
            read_check(3'd3, reg_data_t'(exp_held[code-1]), $sformatf("peak ch%0d", code));
        end
        read_check(3'd4, reg_data_t'(exp_windows), "window count");
        if (odd_codes) begin
            for (int code = 5; code <= 8; code++) begin
                write_reg(3'd2, reg_data_t'(code % 8));
                read_check(3'd3, '0, $sformatf("peak code %0d", code % 8));
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        reg_wr    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        for (int ch = 0; ch < `NUM_CH; ch++) begin
            exp_held[ch] = '0;
            run_max[ch]  = '0;
            for (int f = 0; f < MAX_FRAMES; f++) begin
                exp_vals[ch][f]          = adc_sample_t'($random(seed));
                u_adc.frame_vals[ch][f]  = exp_vals[ch][f];
            end
        end
        repeat (5) @(posedge clk);
        rst_n         <= 1'b1;
        idle_expected <= 1'b1;
        read_check(3'd0, '0, "ctrl");
        read_check(3'd1, reg_data_t'(`WINDOW_DEFAULT), "window_len");
        read_check(3'd2, reg_data_t'(1), "chan_sel");
        read_check(3'd3, '0, "peak");
        read_check(3'd4, '0, "window count");
        repeat (20) @(posedge clk);
        idle_expected <= 1'b0;
        write_reg(3'd0, reg_data_t'(1));
        frames_in_win = 0;
        for (int w = 0; w < 3; w++) begin
            wait_window_done();
            check_window(w == 0);
        end
        // shorter windows, the restart lines up with a frame boundary here
        write_reg(3'd1, reg_data_t'(3));
        tb_win_len    = 3;
        frames_in_win = 0;
        read_check(3'd1, reg_data_t'(3), "window_len");
        for (int w = 0; w < 3; w++) begin
            wait_window_done();
            check_window(1'b0);
        end
        write_reg(3'd0, '0);
        frames_in_win = 0;
        while (!cs_n) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        idle_expected <= 1'b1;
        repeat (3 * FRAME_CYCLES) @(posedge clk);
        read_check(3'd4, reg_data_t'(exp_windows), "window count");
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog/adc_spi_sampler.sv
`include "peak_monitor_cfg.svh"

module adc_spi_sampler
    import peak_monitor_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               enable,
    // miso[0] belongs to channel 1, miso[3] to channel 4
    input  logic [`NUM_CH-1:0] miso,
    output logic               sclk,
    output logic               cs_n,
    output logic               sample_valid,
    output sample_set_t        samples
);

    localparam int DIV_LEN = 2 * `SCLK_HALF;
    localparam int CNT_LEN = (DIV_LEN > `CS_GAP) ? DIV_LEN : `CS_GAP;
    localparam int CNT_W   = $clog2(CNT_LEN);
    localparam int BIT_W   = $clog2(`FRAME_BITS);

    sampler_state_t   state;
    logic [CNT_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;
    adc_sample_t      shift_q [`NUM_CH];

    logic div_last;
    logic gap_last;
    logic rise_tick;
    logic frame_done;

    // the divider counter doubles as the gap counter while cs_n is high
    assign div_last   = (div_cnt == CNT_W'(DIV_LEN - 1));
    assign gap_last   = (div_cnt == CNT_W'(`CS_GAP - 1));
    assign rise_tick  = (state == s_shift) && (div_cnt == CNT_W'(`SCLK_HALF - 1));
    assign frame_done = (state == s_shift) && div_last
                        && (bit_cnt == BIT_W'(`FRAME_BITS - 1));

    // sclk is low for the first half of each period and idles low
    assign cs_n = (state != s_shift);
    assign sclk = (state == s_shift) && (div_cnt >= CNT_W'(`SCLK_HALF));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= s_idle;
            div_cnt      <= '0;
            bit_cnt      <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= frame_done;
            case (state)
                s_idle: begin
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    if (enable) begin
                        state <= s_shift;
                    end
                end
                s_shift: begin
                    if (div_last) begin
                        div_cnt <= '0;
                        if (frame_done) begin
                            bit_cnt <= '0;
                            state   <= s_gap;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                s_gap: begin
                    if (gap_last) begin
                        div_cnt <= '0;
                        // a cleared enable only takes effect between frames
                        state   <= enable ? s_shift : s_idle;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // the two leading zeros drop out of the top of each shift register
    always_ff @(posedge clk) begin
        if (rise_tick) begin
            for (int ch = 0; ch < `NUM_CH; ch++) begin
                shift_q[ch] <= {shift_q[ch][`DATA_BITS-2:0], miso[ch]};
            end
        end
        if (frame_done) begin
            samples.ch1 <= shift_q[0];
            samples.ch2 <= shift_q[1];
            samples.ch3 <= shift_q[2];
            samples.ch4 <= shift_q[3];
        end
    end

    a_idle_cs_high: assert property (@(posedge clk) disable iff (!rst_n)
        (state == s_idle && !enable) |=> cs_n);

    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid);

endmodule

// File: verilog/peak_cache.sv
module peak_cache
    import peak_monitor_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  adc_sample_t sample,
    input  logic        sample_valid,
    input  logic        window_end,
    output adc_sample_t held_peak
);

    adc_sample_t run_max;
    adc_sample_t next_max;

    // the final sample of a window still counts toward its peak
    assign next_max = (sample > run_max) ? sample : run_max;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_max   <= '0;
            held_peak <= '0;
        end else if (sample_valid) begin
            if (window_end) begin
                held_peak <= next_max;
                run_max   <= '0;
            end else begin
                run_max   <= next_max;
            end
        end
    end

    a_max_tracks: assert property (@(posedge clk) disable iff (!rst_n)
        (sample_valid && !window_end) |=> (run_max >= $past(sample)));

endmodule

// File: verilog/peak_monitor_cfg.svh
`ifndef PEAK_MONITOR_CFG_SVH
`define PEAK_MONITOR_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI frame timing, all counts in clk cycles or SCLK periods
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SCLK_HALF       2
// two leading zeros, then the conversion result MSB first
`define FRAME_BITS      12
`define DATA_BITS       10
`define CS_GAP          4
`define NUM_CH          4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register port and window widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define WIN_BITS        16
`define REG_ADDR_BITS   3
`define REG_DATA_BITS   16
`define CHAN_SEL_BITS   3
`define WINDOW_DEFAULT  8

`endif

// File: verilog/peak_monitor_pkg.sv
`include "peak_monitor_cfg.svh"

package peak_monitor_pkg;

    // one conversion result from a single ADC
    typedef logic [`DATA_BITS-1:0] adc_sample_t;

    // one value per channel, ch1 sits in the upper bits
    typedef struct packed {
        adc_sample_t ch1;
        adc_sample_t ch2;
        adc_sample_t ch3;
        adc_sample_t ch4;
    } sample_set_t;

    // window length in frames and the number of completed windows
    typedef logic [`WIN_BITS-1:0] win_len_t;
    typedef logic [`WIN_BITS-1:0] win_count_t;

    typedef logic [`REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [`REG_DATA_BITS-1:0] reg_data_t;

    // codes 1 to 4 pick a channel, anything else reads as zero
    typedef logic [`CHAN_SEL_BITS-1:0] chan_sel_t;

    typedef enum logic [1:0] {
        s_idle,
        s_shift,
        s_gap
    } sampler_state_t;

endpackage

// File: verilog/peak_monitor_top.sv
`include "peak_monitor_cfg.svh"

module peak_monitor_top
    import peak_monitor_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    output logic               sclk,
    output logic               cs_n,
    input  logic [`NUM_CH-1:0] miso,
    input  logic               reg_wr,
    input  reg_addr_t          reg_addr,
    input  reg_data_t          reg_wdata,
    output reg_data_t          reg_rdata,
    output logic               window_done
);

    logic        enable;
    logic        sample_valid;
    logic        window_end;
    logic        window_restart;
    win_len_t    window_len;
    sample_set_t samples;
    // each cache drives its own field
    wire sample_set_t held_peaks;

    adc_spi_sampler u_sampler (
        .clk          (clk),
        .rst_n        (rst_n),
        .enable       (enable),
        .miso         (miso),
        .sclk         (sclk),
        .cs_n         (cs_n),
        .sample_valid (sample_valid),
        .samples      (samples)
    );

    window_timer u_timer (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample_valid   (sample_valid),
        .window_len     (window_len),
        .window_restart (window_restart),
        .window_end     (window_end)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one peak cache per channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    peak_cache u_cache_1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (samples.ch1),
        .sample_valid (sample_valid),
        .window_end   (window_end),
        .held_peak    (held_peaks.ch1)
    );

    peak_cache u_cache_2 (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (samples.ch2),
        .sample_valid (sample_valid),
        .window_end   (window_end),
        .held_peak    (held_peaks.ch2)
    );

    peak_cache u_cache_3 (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (samples.ch3),
        .sample_valid (sample_valid),
        .window_end   (window_end),
        .held_peak    (held_peaks.ch3)
    );

    peak_cache u_cache_4 (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (samples.ch4),
        .sample_valid (sample_valid),
        .window_end   (window_end),
        .held_peak    (held_peaks.ch4)
    );

    peak_regs u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .reg_wr         (reg_wr),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_rdata      (reg_rdata),
        .enable         (enable),
        .window_len     (window_len),
        .window_restart (window_restart),
        .held_peaks     (held_peaks),
        .window_end     (window_end),
        .window_done    (window_done)
    );

endmodule

// File: verilog/peak_regs.sv
`include "peak_monitor_cfg.svh"

module peak_regs
    import peak_monitor_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        reg_wr,
    input  reg_addr_t   reg_addr,
    input  reg_data_t   reg_wdata,
    output reg_data_t   reg_rdata,
    output logic        enable,
    output win_len_t    window_len,
    output logic        window_restart,
    input  sample_set_t held_peaks,
    input  logic        window_end,
    output logic        window_done
);

    localparam reg_addr_t ADDR_CTRL  = 3'd0;
    localparam reg_addr_t ADDR_WLEN  = 3'd1;
    localparam reg_addr_t ADDR_CHSEL = 3'd2;
    localparam reg_addr_t ADDR_PEAK  = 3'd3;
    localparam reg_addr_t ADDR_COUNT = 3'd4;

    localparam chan_sel_t CHANNEL_1 = 3'd1;
    localparam chan_sel_t CHANNEL_2 = 3'd2;
    localparam chan_sel_t CHANNEL_3 = 3'd3;
    localparam chan_sel_t CHANNEL_4 = 3'd4;

    chan_sel_t   chan_sel;
    win_count_t  win_count;
    adc_sample_t sel_peak;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writable registers and window bookkeeping
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable         <= 1'b0;
            window_len     <= win_len_t'(`WINDOW_DEFAULT);
            chan_sel       <= CHANNEL_1;
            window_restart <= 1'b0;
            win_count      <= '0;
            window_done    <= 1'b0;
        end else begin
            // restart lines up with the cycle the new setting takes effect
            window_restart <= reg_wr && ((reg_addr == ADDR_CTRL) || (reg_addr == ADDR_WLEN));
            if (reg_wr) begin
                case (reg_addr)
                    ADDR_CTRL:  enable     <= reg_wdata[0];
                    ADDR_WLEN:  window_len <= reg_wdata;
                    ADDR_CHSEL: chan_sel   <= reg_wdata[`CHAN_SEL_BITS-1:0];
                    default: ;
                endcase
            end
            if (window_end) begin
                win_count <= win_count + 1'b1;
            end
            // registered so it lands with the held peak update
            window_done <= window_end;
        end
    end

    always_comb begin
        case (chan_sel)
            CHANNEL_1: sel_peak = held_peaks.ch1;
            CHANNEL_2: sel_peak = held_peaks.ch2;
            CHANNEL_3: sel_peak = held_peaks.ch3;
            CHANNEL_4: sel_peak = held_peaks.ch4;
            default:   sel_peak = '0;
        endcase
    end

    always_comb begin
        case (reg_addr)
            ADDR_CTRL:  reg_rdata = reg_data_t'(enable);
            ADDR_WLEN:  reg_rdata = reg_data_t'(window_len);
            ADDR_CHSEL: reg_rdata = reg_data_t'(chan_sel);
            ADDR_PEAK:  reg_rdata = reg_data_t'(sel_peak);
            ADDR_COUNT: reg_rdata = reg_data_t'(win_count);
            default:    reg_rdata = '0;
        endcase
    end

endmodule

// File: verilog/window_timer.sv
module window_timer
    import peak_monitor_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     sample_valid,
    input  win_len_t window_len,
    input  logic     window_restart,
    output logic     window_end
);

    win_len_t frame_cnt;
    win_len_t eff_len;
    logic     last_frame;

    // a zero length behaves like a window of one frame
    assign eff_len = (window_len == '0) ? win_len_t'(1) : window_len;

    // compare with >= so a shortened window ends on the next frame
    assign last_frame = (frame_cnt >= eff_len - win_len_t'(1));
    assign window_end = sample_valid && last_frame;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (window_restart) begin
            frame_cnt <= '0;
        end else if (window_end) begin
            frame_cnt <= '0;
        end else if (sample_valid) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    // every window end comes with a strobe and leaves the count at zero
    a_end_with_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        window_end |-> sample_valid ##1 (frame_cnt == '0));

endmodule
